// File: hdl/conv_row_pkg.sv
package conv_row_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int REG_BYTES   = 70;
  localparam int PIX_CHUNK   = 32;
  localparam int SLAB_MAX    = 2;
  localparam int KSIZE       = 3;
  localparam int WIN_CREDITS = 4;

  // derived widths
  localparam int IDX_W    = $clog2(REG_BYTES);
  localparam int PCNT_W   = $clog2(PIX_CHUNK + 1);
  localparam int CRED_W   = $clog2(WIN_CREDITS + 1);
  localparam int ROW_BITS = REG_BYTES * 8;

  // per byte load operation in the row registers
  localparam logic [1:0] OP_CLEAR = 2'd0;
  localparam logic [1:0] OP_SLAB  = 2'd1;
  localparam logic [1:0] OP_PIX   = 2'd2;
  localparam logic [1:0] OP_PAD   = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [KSIZE-1:0][PIX_CHUNK-1:0][7:0] pixels;
    logic [KSIZE-1:0][SLAB_MAX-1:0][7:0]  slab;
    logic [1:0]                           slab_num;
    logic [PCNT_W-1:0]                    pix_count;
    logic [1:0]                           west_pad;
    logic [1:0]                           east_pad;
    logic [KSIZE-1:0]                     row_ok;
    logic [1:0]                           stride;
  } seg_t;

  // pixel span is [reg_start_idx, reg_end_idx)
  // data begins at fill_lo, padded region ends before fill_hi
  typedef struct packed {
    logic [IDX_W-1:0]                     reg_start_idx;
    logic [IDX_W-1:0]                     reg_end_idx;
    logic [IDX_W-1:0]                     fill_lo;
    logic [IDX_W-1:0]                     fill_hi;
    logic [1:0]                           slab_num;
    logic [KSIZE-1:0]                     row_ok;
    logic [KSIZE-1:0][PIX_CHUNK-1:0][7:0] pixels;
    logic [KSIZE-1:0][SLAB_MAX-1:0][7:0]  slab;
  } place_t;

  typedef struct packed {
    logic [IDX_W-1:0] win_count;
    logic [1:0]       stride;
  } scan_t;

  // pix[row][col]
  typedef struct packed {
    logic [KSIZE-1:0][KSIZE-1:0][7:0] pix;
    logic                             last;
  } win_t;

  typedef logic [REG_BYTES-1:0][7:0] reg_row_t;
  typedef reg_row_t [KSIZE-1:0]      rows_t;

endpackage

// File: hdl/row_fill_ctrl.sv
`timescale 1ns/10ps

module row_fill_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 seg_valid,
  input  conv_row_pkg::seg_t   seg,
  output conv_row_pkg::place_t place,
  output logic                 load,
  output conv_row_pkg::scan_t  scan,
  output logic                 scan_go
);
  import conv_row_pkg::*;

  seg_t             seg_r;
  logic [IDX_W-1:0] data_lo;
  logic [IDX_W-1:0] pix_lo;
  logic [IDX_W-1:0] pix_hi;
  logic [IDX_W-1:0] region_len;
  logic [IDX_W-1:0] win_span;
  logic [IDX_W-1:0] win_count;
  logic [1:0]       stride_n;

  //////////////////////////////////////////////////////////////////////
  // segment capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (seg_valid)
    begin
      seg_r <= seg;
    end
  end

  // load and scan start together, one cycle after capture
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      load    <= 1'b0;
      scan_go <= 1'b0;
    end
    else
    begin
      load    <= seg_valid;
      scan_go <= seg_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // placement
  //////////////////////////////////////////////////////////////////////

  // west pad, then slab, then pixels, then east pad
  always_comb
  begin
    data_lo    = IDX_W'(seg_r.west_pad);
    pix_lo     = data_lo + IDX_W'(seg_r.slab_num);
    pix_hi     = pix_lo + IDX_W'(seg_r.pix_count);
    region_len = pix_hi + IDX_W'(seg_r.east_pad);
  end

  always_comb
  begin
    place.reg_start_idx = pix_lo;
    place.reg_end_idx   = pix_hi;
    place.fill_lo       = data_lo;
    place.fill_hi       = region_len;
    place.slab_num      = seg_r.slab_num;
    place.row_ok        = seg_r.row_ok;
    place.pixels        = seg_r.pixels;
    place.slab          = seg_r.slab;
  end

  //////////////////////////////////////////////////////////////////////
  // window count
  //////////////////////////////////////////////////////////////////////

  // anything other than 2 scans at stride 1
  assign stride_n = (seg_r.stride == 2'd2) ? 2'd2 : 2'd1;
  assign win_span = region_len - IDX_W'(KSIZE);

  always_comb
  begin
    if (region_len < IDX_W'(KSIZE))
    begin
      win_count = '0;
    end
    else if (stride_n == 2'd2)
    begin
      win_count = (win_span >> 1) + IDX_W'(1);
    end
    else
    begin
      win_count = win_span + IDX_W'(1);
    end
  end

  assign scan.win_count = win_count;
  assign scan.stride    = stride_n;

endmodule

// File: hdl/row_regs.sv
`timescale 1ns/10ps

module row_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load,
  input  conv_row_pkg::place_t place,
  output conv_row_pkg::rows_t  rows
);
  import conv_row_pkg::*;

  logic [KSIZE-1:0][ROW_BITS-1:0]  pix_shift;
  logic [KSIZE-1:0][ROW_BITS-1:0]  slab_shift;
  logic [KSIZE-1:0][REG_BYTES-1:0][1:0] ops;
  rows_t                           fill;

  //////////////////////////////////////////////////////////////////////
  // source alignment
  //////////////////////////////////////////////////////////////////////

  // pixel chunk moved up to reg_start_idx, slab moved up to fill_lo
  always_comb
  begin
    for (int r = 0; r < KSIZE; r++)
    begin
      pix_shift[r]  = ROW_BITS'(place.pixels[r]) << {place.reg_start_idx, 3'b000};
      slab_shift[r] = ROW_BITS'(place.slab[r]) << {place.fill_lo, 3'b000};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // per byte operation codes
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int r = 0; r < KSIZE; r++)
    begin
      for (int b = 0; b < REG_BYTES; b++)
      begin
        if (!place.row_ok[r] || (b >= place.fill_hi))
        begin
          // border row, or past the padded region
          ops[r][b] = OP_CLEAR;
        end
        else if ((b < place.fill_lo) || (b >= place.reg_end_idx))
        begin
          ops[r][b] = OP_PAD;
        end
        else if (b < (place.fill_lo + place.slab_num))
        begin
          ops[r][b] = OP_SLAB;
        end
        else
        begin
          ops[r][b] = OP_PIX;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // byte select
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int r = 0; r < KSIZE; r++)
    begin
      for (int b = 0; b < REG_BYTES; b++)
      begin
        case (ops[r][b])
          OP_SLAB:
          begin
            fill[r][b] = slab_shift[r][b*8 +: 8];
          end
          OP_PIX:
          begin
            fill[r][b] = pix_shift[r][b*8 +: 8];
          end
          // clear and pad both write zero
          default:
          begin
            fill[r][b] = 8'h00;
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // row registers
  //////////////////////////////////////////////////////////////////////

  // all three rows load in one clock, hold otherwise
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rows <= '0;
    end
    else if (load)
    begin
      rows <= fill;
    end
  end

endmodule

// File: hdl/window_shifter.sv
`timescale 1ns/10ps

module window_shifter (
  input  logic                clk,
  input  logic                reset,
  input  logic                scan_go,
  input  conv_row_pkg::scan_t scan,
  input  conv_row_pkg::rows_t rows,
  output logic                win_valid,
  output conv_row_pkg::win_t  win,
  input  logic                win_credit,
  output logic                seg_credit
);
  import conv_row_pkg::*;

  logic              active;
  logic [IDX_W-1:0]  col;
  logic [IDX_W-1:0]  remaining;
  logic [1:0]        stride_r;
  logic [CRED_W-1:0] credits;
  logic [IDX_W-1:0]  col_idx;

  // a window goes out whenever work and credit remain
  assign win_valid = active && (credits != '0);

  //////////////////////////////////////////////////////////////////////
  // window credits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      credits <= CRED_W'(WIN_CREDITS);
    end
    else
    begin
      case ({win_valid, win_credit})
        2'b10:   credits <= credits - CRED_W'(1);
        2'b01:   credits <= credits + CRED_W'(1);
        default: credits <= credits;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // scan control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      active     <= 1'b0;
      col        <= '0;
      remaining  <= '0;
      stride_r   <= 2'd1;
      seg_credit <= 1'b0;
    end
    else
    begin
      seg_credit <= 1'b0;
      if (scan_go)
      begin
        col        <= '0;
        remaining  <= scan.win_count;
        stride_r   <= scan.stride;
        active     <= (scan.win_count != '0);
        // hand the credit back at once for a short region
        seg_credit <= (scan.win_count == '0);
      end
      else if (win_valid)
      begin
        col       <= col + IDX_W'(stride_r);
        remaining <= remaining - IDX_W'(1);
        if (remaining == IDX_W'(1))
        begin
          active     <= 1'b0;
          seg_credit <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // window select
  //////////////////////////////////////////////////////////////////////

  // columns col..col+2 of every row
  always_comb
  begin
    col_idx = col;
    for (int r = 0; r < KSIZE; r++)
    begin
      for (int k = 0; k < KSIZE; k++)
      begin
        col_idx       = col + IDX_W'(k);
        win.pix[r][k] = rows[r][col_idx];
      end
    end
    win.last = (remaining == IDX_W'(1));
  end

endmodule

// File: hdl/conv_row_top.sv
`timescale 1ns/10ps

module conv_row_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               seg_valid,
  input  conv_row_pkg::seg_t seg,
  output logic               seg_credit,
  output logic               win_valid,
  output conv_row_pkg::win_t win,
  input  logic               win_credit
);
  import conv_row_pkg::*;

  place_t place;
  scan_t  scan;
  rows_t  rows;
  logic   load;
  logic   scan_go;

  // segment capture and placement
  row_fill_ctrl u_fill (
    .clk       (clk),
    .reset     (reset),
    .seg_valid (seg_valid),
    .seg       (seg),
    .place     (place),
    .load      (load),
    .scan      (scan),
    .scan_go   (scan_go)
  );

  // three register rows
  row_regs u_regs (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .place (place),
    .rows  (rows)
  );

  // window walk under credits
  window_shifter u_shift (
    .clk        (clk),
    .reset      (reset),
    .scan_go    (scan_go),
    .scan       (scan),
    .rows       (rows),
    .win_valid  (win_valid),
    .win        (win),
    .win_credit (win_credit),
    .seg_credit (seg_credit)
  );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // 8 ns period
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held over the first four rising edges
  initial
  begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: test/conv_row_props.sv
`timescale 1ns/10ps

module conv_row_props (
  input logic                            clk,
  input logic                            reset,
  input logic                            scan_go,
  input logic                            active,
  input logic                            win_valid,
  input logic                            win_credit,
  input logic [conv_row_pkg::CRED_W-1:0] credits
);
  import conv_row_pkg::*;

  int fail_count = 0;
  int granted;

  // credits held, counted from the credit handshake alone
  always @(posedge clk)
  begin
    if (reset)
    begin
      granted <= WIN_CREDITS;
    end
    else
    begin
      granted <= granted + int'(win_credit) - int'(win_valid);
    end
  end

  // downstream can only hand back credits it was given
  credit_bound: assert property (@(posedge clk) disable iff (reset)
    credits <= CRED_W'(WIN_CREDITS))
  else
  begin
    fail_count++;
    $error("window credit count above %0d", WIN_CREDITS);
  end

  valid_needs_credit: assert property (@(posedge clk) disable iff (reset)
    win_valid |-> (granted > 0))
  else
  begin
    fail_count++;
    $error("win_valid asserted with zero window credits");
  end

  // single segment credit keeps scans apart
  no_overlap: assert property (@(posedge clk) disable iff (reset)
    scan_go |-> !active)
  else
  begin
    fail_count++;
    $error("scan_go arrived while a scan was still active");
  end

endmodule

bind window_shifter conv_row_props props (
  .clk        (clk),
  .reset      (reset),
  .scan_go    (scan_go),
  .active     (active),
  .win_valid  (win_valid),
  .win_credit (win_credit),
  .credits    (credits)
);

// File: test/conv_row_tb.sv
`timescale 1ns/10ps

module conv_row_tb;
  import conv_row_pkg::*;

  localparam int SEG_TOTAL = 33;
  localparam int HOLD_MAX  = 12;
  localparam int MAX_WIN   = 38;
  // worst stall of one segment with every credit held HOLD_MAX cycles
  localparam int SEG_DELAY   = MAX_WIN * (HOLD_MAX + 1);
  localparam int CYCLE_LIMIT = SEG_TOTAL * (REG_BYTES + 10 + SEG_DELAY) * 2;

  logic clk;
  logic reset;
  logic seg_valid;
  seg_t seg;
  logic seg_credit;
  logic win_valid;
  win_t win;
  logic win_credit = 1'b0;

  seg_t sent_q[$];
  int   errors = 0;
  int   win_idx = 0;
  int   win_total = 0;
  int   seg_total = 0;
  int   owed = 0;
  int   tb_credits = WIN_CREDITS;
  int   hold = 0;
  int   hold_max = 1;
  int   cycles = 0;

  tb_clock_gen clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  conv_row_top DUT (
    .clk        (clk),
    .reset      (reset),
    .seg_valid  (seg_valid),
    .seg        (seg),
    .seg_credit (seg_credit),
    .win_valid  (win_valid),
    .win        (win),
    .win_credit (win_credit)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int window_count(input seg_t s);
    int len;
    len = int'(s.west_pad) + int'(s.slab_num) + int'(s.pix_count) + int'(s.east_pad);
    if (len < KSIZE)
      return 0;
    return (len - KSIZE) / int'(s.stride) + 1;
  endfunction

  // west pad, slab, pixels, then zeros
  function automatic logic [7:0] byte_at(input seg_t s, input int r, input int col);
    int w;
    int sl;
    int p;
    w  = s.west_pad;
    sl = w + int'(s.slab_num);
    p  = sl + int'(s.pix_count);
    if (!s.row_ok[r] || (col < w) || (col >= p))
      return 8'h00;
    if (col < sl)
      return s.slab[r][col - w];
    return s.pixels[r][col - sl];
  endfunction

  function automatic win_t expected_window(input seg_t s, input int c);
    win_t w;
    for (int r = 0; r < KSIZE; r++)
      for (int k = 0; k < KSIZE; k++)
        w.pix[r][k] = byte_at(s, r, c * int'(s.stride) + k);
    w.last = (c == window_count(s) - 1);
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR %s", msg);
  endtask

  task automatic report_test(input string name, input int err0, input int win0);
    $display("test %s: %0d windows, %0d errors", name, win_total - win0, errors - err0);
  endtask

  task automatic make_segment(output seg_t s, input int stride, input int slab_num,
                              input int pix_count, input int west, input int east,
                              input logic [2:0] row_ok);
    for (int r = 0; r < KSIZE; r++)
    begin
      for (int j = 0; j < PIX_CHUNK; j++)
        s.pixels[r][j] = 8'($urandom);
      for (int j = 0; j < SLAB_MAX; j++)
        s.slab[r][j] = 8'($urandom);
    end
    s.slab_num  = 2'(slab_num);
    s.pix_count = PCNT_W'(pix_count);
    s.west_pad  = 2'(west);
    s.east_pad  = 2'(east);
    s.row_ok    = row_ok;
    s.stride    = 2'(stride);
  endtask

  // spends the segment credit, then waits for it to come back
  task automatic send_segment(input seg_t s, output int latency);
    repeat ($urandom_range(3, 1)) @(posedge clk);
    seg_valid <= 1'b1;
    seg       <= s;
    sent_q.push_back(s);
    @(posedge clk);
    seg_valid <= 1'b0;
    latency = 0;
    do
    begin
      @(posedge clk);
      latency++;
    end
    while (!seg_credit);
    seg_total++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // window compare and segment credit tracking
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (win_valid)
      begin
        if (sent_q.size() == 0)
          report_error("window emitted with no segment outstanding");
        else if (win_idx >= window_count(sent_q[0]))
          report_error("extra window beyond the window count of the segment");
        else
          check_value("win", win, expected_window(sent_q[0], win_idx));
        win_idx++;
        win_total++;
      end
      if (seg_credit)
      begin
        if (sent_q.size() == 0)
        begin
          report_error("seg_credit pulsed with no segment outstanding");
        end
        else
        begin
          if (win_idx != window_count(sent_q[0]))
            report_error($sformatf("segment ended after %0d of %0d windows",
                                   win_idx, window_count(sent_q[0])));
          void'(sent_q.pop_front());
        end
        win_idx = 0;
      end
    end
  end

  // downstream returns one held credit at a time after a random hold
  always @(posedge clk)
  begin
    if (reset)
    begin
      owed       = 0;
      tb_credits = WIN_CREDITS;
      hold       = 0;
      win_credit <= 1'b0;
    end
    else
    begin
      if (win_valid && (tb_credits == 0))
        report_error("win_valid asserted with no window credit left");
      tb_credits = tb_credits - int'(win_valid) + int'(win_credit);
      owed       = owed + int'(win_valid);
      if ((owed > 0) && (hold == 0))
      begin
        win_credit <= 1'b1;
        owed--;
        hold = $urandom_range(hold_max, 0);
      end
      else
      begin
        win_credit <= 1'b0;
        if (hold > 0)
          hold--;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, a window or segment credit never arrived", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    seg_t s;
    int   lat;
    int   err0;
    int   win0;
    void'($urandom(89241));
    seg_valid  = 1'b0;
    seg        = '0;
    do @(posedge clk); while (reset);

    // nothing may come out before the first segment
    err0 = errors;
    win0 = win_total;
    repeat (16)
    begin
      @(posedge clk);
      check_value("win_valid", win_valid, 1'b0);
      check_value("seg_credit", seg_credit, 1'b0);
    end
    report_test("reset_idle", err0, win0);

    err0 = errors;
    win0 = win_total;
    for (int i = 0; i < 6; i++)
    begin
      make_segment(s, 1, $urandom_range(2, 0), PIX_CHUNK, $urandom_range(3, 0),
                   $urandom_range(3, 0), 3'b111);
      send_segment(s, lat);
    end
    report_test("full_stride1", err0, win0);

    err0 = errors;
    win0 = win_total;
    for (int i = 0; i < 9; i++)
    begin
      make_segment(s, 2, i % 3, $urandom_range(PIX_CHUNK, 1), $urandom_range(3, 0),
                   $urandom_range(3, 0), 3'b111);
      send_segment(s, lat);
    end
    report_test("stride2_pad_slab", err0, win0);

    err0 = errors;
    win0 = win_total;
    for (int i = 0; i < 8; i++)
    begin
      make_segment(s, $urandom_range(2, 1), $urandom_range(2, 0),
                   $urandom_range(PIX_CHUNK, 4), $urandom_range(3, 0),
                   $urandom_range(3, 0), 3'(i));
      send_segment(s, lat);
    end
    report_test("border_rows", err0, win0);

    // long credit holds
    err0     = errors;
    win0     = win_total;
    hold_max = HOLD_MAX;
    for (int i = 0; i < 6; i++)
    begin
      make_segment(s, 1, 2, PIX_CHUNK, 3, 3, 3'b111);
      send_segment(s, lat);
    end
    hold_max = 1;
    report_test("back_pressure", err0, win0);

    // regions of one or two bytes give no windows
    err0 = errors;
    win0 = win_total;
    for (int i = 0; i < 4; i++)
    begin
      make_segment(s, $urandom_range(2, 1), i % 2, (i == 2) ? 2 : 1, 0, 0, 3'b111);
      send_segment(s, lat);
      check_value("seg_credit latency", lat, 2);
    end
    report_test("short_region", err0, win0);

    // every window credit must be home again
    while ((owed != 0) || win_credit)
      @(posedge clk);
    repeat (3) @(posedge clk);
    check_value("window credits", DUT.u_shift.credits, WIN_CREDITS);
    if (sent_q.size() != 0)
      report_error("segments left without a returned credit");
    errors += DUT.u_shift.props.fail_count;

    $display("summary: %0d segments, %0d windows, %0d errors", seg_total, win_total, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// File: build.f
hdl/conv_row_pkg.sv
hdl/row_fill_ctrl.sv
hdl/row_regs.sv
hdl/window_shifter.sv
hdl/conv_row_top.sv
test/tb_clock_gen.sv
test/conv_row_props.sv
test/conv_row_tb.sv

// File: Bender.yml
package:
  name: conv_row

sources:
  # design, package first
  - hdl/conv_row_pkg.sv
  - hdl/row_fill_ctrl.sv
  - hdl/row_regs.sv
  - hdl/window_shifter.sv
  - hdl/conv_row_top.sv

  # testbench
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/conv_row_props.sv
      - test/conv_row_tb.sv
